//--- hdl/bpfcap_pkg.sv
package bpfcap_pkg;

    // datapath sizes
    localparam int NUM_TAPS   = 8;
    localparam int DATA_W     = 32;
    localparam int COEF_W     = 16;
    localparam int BURST_W    = 16;
    localparam int TAP_SEL_W  = $clog2(NUM_TAPS);

    // result FIFO, the credit count spans 0 to FIFO_DEPTH
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    // slave register map
    localparam int CSR_AW = 3;
    localparam logic [CSR_AW-1:0] REG_CONTROL       = 3'd0;
    localparam logic [CSR_AW-1:0] REG_PKT_BEGIN     = 3'd1;
    localparam logic [CSR_AW-1:0] REG_PKT_END       = 3'd2;
    localparam logic [CSR_AW-1:0] REG_WRITE_ADDRESS = 3'd3;
    localparam logic [CSR_AW-1:0] REG_COEF_SEL      = 3'd4;
    localparam logic [CSR_AW-1:0] REG_COEF_DATA     = 3'd5;

    // control register bits
    localparam int CTRL_START = 0;
    localparam int CTRL_BUSY  = 1;
    localparam int CTRL_DONE  = 2;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_WAIT_DATA
    } reader_state_e;

    typedef enum logic {
        WR_IDLE,
        WR_WRITE
    } writer_state_e;

endpackage

//--- hdl/bpfcap_csr_if.sv
interface bpfcap_csr_if;
    import bpfcap_pkg::*;

    logic              start;
    logic [DATA_W-1:0] pkt_begin;
    logic [DATA_W-1:0] pkt_end;
    logic [DATA_W-1:0] write_address;
    logic              done;

    modport csr (
        output start, pkt_begin, pkt_end, write_address,
        input  done
    );

    modport reader (
        input start, pkt_begin, pkt_end
    );

    modport writer (
        input  start, write_address,
        output done
    );
endinterface

//--- hdl/bpfcap_tap_if.sv
interface bpfcap_tap_if;
    import bpfcap_pkg::*;

    logic                 coef_we;
    logic [TAP_SEL_W-1:0] coef_sel;
    logic [COEF_W-1:0]    coef_data;
    logic                 clear;

    modport csr (
        output coef_we, coef_sel, coef_data, clear
    );

    modport tap (
        input coef_we, coef_sel, coef_data, clear
    );
endinterface

//--- hdl/bpfcap_csr.sv
module bpfcap_csr (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [bpfcap_pkg::CSR_AW-1:0] avs_s0_address,
    input  logic                          avs_s0_write,
    input  logic [bpfcap_pkg::DATA_W-1:0] avs_s0_writedata,
    input  logic                          avs_s0_read,
    output logic [bpfcap_pkg::DATA_W-1:0] avs_s0_readdata,
    bpfcap_csr_if.csr                     csr,
    bpfcap_tap_if.csr                     tap
);
    import bpfcap_pkg::*;

    logic              busy;
    logic              done_bit;
    logic              start_q;
    logic              start_req;
    logic              cfg_write;
    logic [DATA_W-1:0] control_word;

    // settings and coefficients are frozen for the length of a run
    assign cfg_write = avs_s0_write && !busy;
    assign start_req = cfg_write && (avs_s0_address == REG_CONTROL)
                       && avs_s0_writedata[CTRL_START];

    // the taps clear their partial sums on the same cycle the run starts
    assign csr.start = start_q;
    assign tap.clear = start_q;

    always_comb begin
        control_word = '0;
        control_word[CTRL_BUSY] = busy;
        control_word[CTRL_DONE] = done_bit;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy              <= 1'b0;
            done_bit          <= 1'b0;
            start_q           <= 1'b0;
            csr.pkt_begin     <= '0;
            csr.pkt_end       <= '0;
            csr.write_address <= '0;
            tap.coef_sel      <= '0;
            tap.coef_we       <= 1'b0;
        end else begin
            start_q     <= start_req;
            tap.coef_we <= cfg_write && (avs_s0_address == REG_COEF_DATA);

            if (start_req) begin
                busy     <= 1'b1;
                done_bit <= 1'b0;
            end else if (csr.done) begin
                busy     <= 1'b0;
                done_bit <= 1'b1;
            end

            if (cfg_write) begin
                case (avs_s0_address)
                    REG_PKT_BEGIN:     csr.pkt_begin     <= avs_s0_writedata;
                    REG_PKT_END:       csr.pkt_end       <= avs_s0_writedata;
                    REG_WRITE_ADDRESS: csr.write_address <= avs_s0_writedata;
                    REG_COEF_SEL:      tap.coef_sel      <= avs_s0_writedata[TAP_SEL_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // coefficient value goes out with the coef_we pulse
    always_ff @(posedge clk) begin
        if (cfg_write && (avs_s0_address == REG_COEF_DATA)) begin
            tap.coef_data <= avs_s0_writedata[COEF_W-1:0];
        end
    end

    // read data is valid on the cycle after read
    always_ff @(posedge clk) begin
        if (avs_s0_read) begin
            case (avs_s0_address)
                REG_CONTROL:       avs_s0_readdata <= control_word;
                REG_PKT_BEGIN:     avs_s0_readdata <= csr.pkt_begin;
                REG_PKT_END:       avs_s0_readdata <= csr.pkt_end;
                REG_WRITE_ADDRESS: avs_s0_readdata <= csr.write_address;
                REG_COEF_SEL:      avs_s0_readdata <= DATA_W'(tap.coef_sel);
                default:           avs_s0_readdata <= '0;
            endcase
        end
    end

    // reader and writer sample these settings throughout the run
    a_settings_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        busy |=> $stable(csr.pkt_begin) && $stable(csr.pkt_end)
                 && $stable(csr.write_address)
    ) else $error("run settings changed while busy");

endmodule

//--- hdl/bpfcap_reader.sv
module bpfcap_reader (
    input  logic                            clk,
    input  logic                            arst_n,
    output logic [bpfcap_pkg::DATA_W-1:0]   avs_m0_address,
    output logic [bpfcap_pkg::BURST_W-1:0]  avs_m0_burstcount,
    output logic                            avs_m0_read,
    input  logic [bpfcap_pkg::DATA_W-1:0]   avs_m0_readdata,
    input  logic                            avs_m0_readdatavalid,
    input  logic                            avs_m0_waitrequest,
    bpfcap_csr_if.reader                    csr,
    input  logic [bpfcap_pkg::CREDIT_W-1:0] credit_free,
    output logic                            sample_valid,
    output logic signed [bpfcap_pkg::COEF_W-1:0] sample,
    output logic                            sample_last
);
    import bpfcap_pkg::*;

    reader_state_e     state;
    logic [DATA_W-1:0] next_addr;
    logic              last_word;
    logic              credit_ok;

    assign avs_m0_burstcount = BURST_W'(1);
    assign next_addr = avs_m0_address + DATA_W'(4);
    assign last_word = next_addr >= csr.pkt_end;

    // the sample strobed this cycle is not yet taken off credit_free
    assign credit_ok = credit_free > CREDIT_W'(sample_valid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= RD_IDLE;
            avs_m0_address <= '0;
            avs_m0_read    <= 1'b0;
            sample_valid   <= 1'b0;
            sample_last    <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            sample_last  <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (csr.start) begin
                        avs_m0_address <= csr.pkt_begin;
                        state          <= RD_ISSUE;
                    end
                end
                RD_ISSUE: begin
                    // once raised, read holds until the slave takes it
                    if (!avs_m0_read) begin
                        avs_m0_read <= credit_ok;
                    end else if (!avs_m0_waitrequest) begin
                        avs_m0_read <= 1'b0;
                        state       <= RD_WAIT_DATA;
                    end
                end
                RD_WAIT_DATA: begin
                    if (avs_m0_readdatavalid) begin
                        sample_valid   <= 1'b1;
                        sample_last    <= last_word;
                        avs_m0_address <= next_addr;
                        state          <= last_word ? RD_IDLE : RD_ISSUE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_WAIT_DATA && avs_m0_readdatavalid) begin
            sample <= avs_m0_readdata[COEF_W-1:0];
        end
    end

    a_no_stray_data: assert property (
        @(posedge clk) disable iff (!arst_n)
        avs_m0_readdatavalid |-> state != RD_IDLE
    ) else $error("readdatavalid with no read outstanding");

endmodule

//--- hdl/bpfcap_tap.sv
module bpfcap_tap #(
    parameter int TAP_INDEX = 0
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    bpfcap_tap_if.tap                            tap,
    input  logic                                 sample_valid,
    input  logic signed [bpfcap_pkg::COEF_W-1:0] sample,
    input  logic [bpfcap_pkg::DATA_W-1:0]        sum_in,
    output logic [bpfcap_pkg::DATA_W-1:0]        sum_out
);
    import bpfcap_pkg::*;

    localparam bit LAST_STAGE = (TAP_INDEX == NUM_TAPS - 1);

    logic signed [COEF_W-1:0] coef;
    logic signed [DATA_W-1:0] product;
    logic [DATA_W-1:0]        addend;

    // full 32-bit signed product, the sum wraps
    assign product = coef * sample;
    assign addend  = LAST_STAGE ? '0 : sum_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coef    <= '0;
            sum_out <= '0;
        end else begin
            if (tap.coef_we && tap.coef_sel == TAP_SEL_W'(TAP_INDEX)) begin
                coef <= tap.coef_data;
            end
            if (tap.clear) begin
                sum_out <= '0;
            end else if (sample_valid) begin
                sum_out <= product + addend;
            end
        end
    end

endmodule

//--- hdl/bpfcap_writer.sv
module bpfcap_writer (
    input  logic                            clk,
    input  logic                            arst_n,
    bpfcap_csr_if.writer                    csr,
    input  logic                            sample_valid,
    input  logic                            sample_last,
    input  logic [bpfcap_pkg::DATA_W-1:0]   result,
    output logic [bpfcap_pkg::CREDIT_W-1:0] credit_free,
    output logic [bpfcap_pkg::DATA_W-1:0]   avs_m1_address,
    output logic [bpfcap_pkg::BURST_W-1:0]  avs_m1_burstcount,
    output logic                            avs_m1_write,
    output logic [bpfcap_pkg::DATA_W-1:0]   avs_m1_writedata,
    input  logic                            avs_m1_waitrequest
);
    import bpfcap_pkg::*;

    writer_state_e      state;
    logic [DATA_W:0]    fifo_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic               valid_q;
    logic               last_q;
    logic               last_word;
    logic               push;
    logic               pop;
    logic               accept;

    assign avs_m1_burstcount = BURST_W'(1);

    // tap 0 holds the result one cycle after the sample strobe
    assign push   = valid_q;
    assign pop    = (state == WR_IDLE) && (count != '0);
    assign accept = avs_m1_write && !avs_m1_waitrequest;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= {last_q, result};
        end
        if (pop) begin
            {last_word, avs_m1_writedata} <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= WR_IDLE;
            valid_q        <= 1'b0;
            last_q         <= 1'b0;
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            credit_free    <= CREDIT_W'(FIFO_DEPTH);
            avs_m1_write   <= 1'b0;
            avs_m1_address <= '0;
            csr.done       <= 1'b0;
        end else begin
            valid_q  <= sample_valid;
            last_q   <= sample_last;
            csr.done <= accept && last_word;

            // a slot is promised at the sample strobe and freed on accept
            credit_free <= credit_free - CREDIT_W'(sample_valid) + CREDIT_W'(accept);
            count       <= count + CREDIT_W'(push) - CREDIT_W'(pop);
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (csr.start) begin
                avs_m1_address <= csr.write_address;
            end

            case (state)
                WR_IDLE: begin
                    if (pop) begin
                        avs_m1_write <= 1'b1;
                        state        <= WR_WRITE;
                    end
                end
                WR_WRITE: begin
                    if (!avs_m1_waitrequest) begin
                        avs_m1_write   <= 1'b0;
                        avs_m1_address <= avs_m1_address + DATA_W'(4);
                        state          <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // the reader's credit check keeps the FIFO from filling past depth
    a_fifo_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        push && !pop |-> count < CREDIT_W'(FIFO_DEPTH)
    ) else $error("result FIFO overflow");

    a_write_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        avs_m1_write && avs_m1_waitrequest |=>
            avs_m1_write && $stable(avs_m1_writedata) && $stable(avs_m1_address)
    ) else $error("m1 write changed under waitrequest");

endmodule

//--- hdl/bpfcap_top.sv
module bpfcap_top (
    input  logic                           clk,
    input  logic                           arst_n,

    input  logic [bpfcap_pkg::CSR_AW-1:0]  avs_s0_address,
    input  logic                           avs_s0_write,
    input  logic [bpfcap_pkg::DATA_W-1:0]  avs_s0_writedata,
    input  logic                           avs_s0_read,
    output logic [bpfcap_pkg::DATA_W-1:0]  avs_s0_readdata,

    output logic [bpfcap_pkg::DATA_W-1:0]  avs_m0_address,
    output logic [bpfcap_pkg::BURST_W-1:0] avs_m0_burstcount,
    output logic                           avs_m0_read,
    input  logic [bpfcap_pkg::DATA_W-1:0]  avs_m0_readdata,
    input  logic                           avs_m0_readdatavalid,
    input  logic                           avs_m0_waitrequest,

    output logic [bpfcap_pkg::DATA_W-1:0]  avs_m1_address,
    output logic [bpfcap_pkg::BURST_W-1:0] avs_m1_burstcount,
    output logic                           avs_m1_write,
    output logic [bpfcap_pkg::DATA_W-1:0]  avs_m1_writedata,
    input  logic                           avs_m1_waitrequest
);
    import bpfcap_pkg::*;

    bpfcap_csr_if csr_bus ();
    bpfcap_tap_if tap_bus ();

    logic                     sample_valid;
    logic signed [COEF_W-1:0] sample;
    logic                     sample_last;
    logic [CREDIT_W-1:0]      credit_free;

    // partial sums run from the last tap down to tap 0
    logic [DATA_W-1:0] tap_sum [NUM_TAPS+1];

    bpfcap_csr csr_inst (
        .clk, .arst_n,
        .avs_s0_address, .avs_s0_write, .avs_s0_writedata,
        .avs_s0_read, .avs_s0_readdata,
        .csr (csr_bus.csr),
        .tap (tap_bus.csr)
    );

    bpfcap_reader reader_inst (
        .clk, .arst_n,
        .avs_m0_address, .avs_m0_burstcount, .avs_m0_read,
        .avs_m0_readdata, .avs_m0_readdatavalid, .avs_m0_waitrequest,
        .csr (csr_bus.reader),
        .credit_free, .sample_valid, .sample, .sample_last
    );

    assign tap_sum[NUM_TAPS] = '0;

    for (genvar i = 0; i < NUM_TAPS; i++) begin : g_tap
        bpfcap_tap #(.TAP_INDEX(i)) tap_inst (
            .clk, .arst_n,
            .tap          (tap_bus.tap),
            .sample_valid (sample_valid),
            .sample       (sample),
            .sum_in       (tap_sum[i+1]),
            .sum_out      (tap_sum[i])
        );
    end

    bpfcap_writer writer_inst (
        .clk, .arst_n,
        .csr          (csr_bus.writer),
        .sample_valid (sample_valid),
        .sample_last  (sample_last),
        .result       (tap_sum[0]),
        .credit_free  (credit_free),
        .avs_m1_address, .avs_m1_burstcount, .avs_m1_write,
        .avs_m1_writedata, .avs_m1_waitrequest
    );

endmodule

//--- testbench/tb_avalon_mem.sv
module tb_avalon_mem #(
    parameter int WORDS = 1024
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic [31:0] m0_address,
    input  logic        m0_read,
    output logic [31:0] m0_readdata,
    output logic        m0_readdatavalid,
    output logic        m0_waitrequest,
    input  logic [31:0] m1_address,
    input  logic        m1_write,
    input  logic [31:0] m1_writedata,
    output logic        m1_waitrequest
);
    localparam int IDX_W = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    logic             rd_pending;
    logic [IDX_W-1:0] rd_index;
    logic [1:0]       rd_delay;

    function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
        return addr[IDX_W+1:2];
    endfunction

    initial begin
        m0_readdata      <= '0;
        m0_readdatavalid <= 1'b0;
        m0_waitrequest   <= 1'b1;
        m1_waitrequest   <= 1'b1;
        rd_pending       <= 1'b0;
        rd_index         <= '0;
        rd_delay         <= '0;
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            m0_readdatavalid <= 1'b0;
            m0_waitrequest   <= 1'b1;
            m1_waitrequest   <= 1'b1;
            rd_pending       <= 1'b0;
        end else begin
            // m0 stalls about one cycle in three, m1 most cycles so the result FIFO fills
            m0_waitrequest   <= ($urandom % 3) == 0;
            m1_waitrequest   <= ($urandom % 6) != 0;
            m0_readdatavalid <= 1'b0;

            if (m0_read && !m0_waitrequest) begin
                rd_pending <= 1'b1;
                rd_index   <= word_index(m0_address);
                rd_delay   <= 2'($urandom % 3);
            end else if (rd_pending) begin
                if (rd_delay == 2'd0) begin
                    m0_readdatavalid <= 1'b1;
                    m0_readdata      <= mem[rd_index];
                    rd_pending       <= 1'b0;
                end else begin
                    rd_delay <= rd_delay - 2'd1;
                end
            end

            if (m1_write && !m1_waitrequest) begin
                mem[word_index(m1_address)] <= m1_writedata;
            end
            if (load_en) begin
                mem[word_index(load_addr)] <= load_data;
            end
        end
    end

endmodule

//--- testbench/tb_bpfcap_top.sv
module tb_bpfcap_top;
    import bpfcap_pkg::*;

    localparam int MAX_WORDS      = 64;
    localparam int TOTAL_WORDS    = 12 + 64 + 20;
    localparam int TIMEOUT_CYCLES = 200 * TOTAL_WORDS + 2000;
    localparam int RESTART_AFTER  = 4;

    logic                 clk;
    logic                 arst_n;
    logic [CSR_AW-1:0]    avs_s0_address;
    logic                 avs_s0_write;
    logic [DATA_W-1:0]    avs_s0_writedata;
    logic                 avs_s0_read;
    logic [DATA_W-1:0]    avs_s0_readdata;
    logic [DATA_W-1:0]    avs_m0_address;
    logic [BURST_W-1:0]   avs_m0_burstcount;
    logic                 avs_m0_read;
    logic [DATA_W-1:0]    avs_m0_readdata;
    logic                 avs_m0_readdatavalid;
    logic                 avs_m0_waitrequest;
    logic [DATA_W-1:0]    avs_m1_address;
    logic [BURST_W-1:0]   avs_m1_burstcount;
    logic                 avs_m1_write;
    logic [DATA_W-1:0]    avs_m1_writedata;
    logic                 avs_m1_waitrequest;
    logic                 load_en;
    logic [DATA_W-1:0]    load_addr;
    logic [DATA_W-1:0]    load_data;

    // expected state of the current run
    logic signed [COEF_W-1:0] coef_ref [NUM_TAPS];
    logic signed [COEF_W-1:0] sample_ref [MAX_WORDS];
    logic [DATA_W-1:0]        exp_base;
    logic [DATA_W-1:0]        pkt_lo;
    logic [DATA_W-1:0]        pkt_hi;
    logic                     run_active;
    int                       exp_count;
    int                       run_first;
    int                       total_writes = 0;
    int                       cycle_count = 0;

    bpfcap_top bpfcap_top_inst (
        .clk, .arst_n,
        .avs_s0_address, .avs_s0_write, .avs_s0_writedata,
        .avs_s0_read, .avs_s0_readdata,
        .avs_m0_address, .avs_m0_burstcount, .avs_m0_read,
        .avs_m0_readdata, .avs_m0_readdatavalid, .avs_m0_waitrequest,
        .avs_m1_address, .avs_m1_burstcount, .avs_m1_write,
        .avs_m1_writedata, .avs_m1_waitrequest
    );

    tb_avalon_mem mem_inst (
        .clk, .arst_n, .load_en, .load_addr, .load_data,
        .m0_address       (avs_m0_address),
        .m0_read          (avs_m0_read),
        .m0_readdata      (avs_m0_readdata),
        .m0_readdatavalid (avs_m0_readdatavalid),
        .m0_waitrequest   (avs_m0_waitrequest),
        .m1_address       (avs_m1_address),
        .m1_write         (avs_m1_write),
        .m1_writedata     (avs_m1_writedata),
        .m1_waitrequest   (avs_m1_waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // y[n] = sum of c[k] * x[n-k], samples before the packet are zero
    function automatic logic [DATA_W-1:0] fir_ref(input int n);
        logic signed [DATA_W-1:0] acc;
        logic signed [DATA_W-1:0] prod;
        acc = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            if (n - k >= 0) begin
                prod = DATA_W'(coef_ref[k]) * DATA_W'(sample_ref[n - k]);
                acc  = acc + prod;
            end
        end
        return acc;
    endfunction

    task automatic csr_write(input logic [CSR_AW-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        avs_s0_address   <= addr;
        avs_s0_writedata <= data;
        avs_s0_write     <= 1'b1;
        @(posedge clk);
        avs_s0_write <= 1'b0;
    endtask

    task automatic csr_read(input logic [CSR_AW-1:0] addr, output logic [DATA_W-1:0] data);
        @(posedge clk);
        avs_s0_address <= addr;
        avs_s0_read    <= 1'b1;
        @(posedge clk);
        avs_s0_read <= 1'b0;
        @(posedge clk);
        data = avs_s0_readdata;
    endtask

    task automatic check_reg(input logic [CSR_AW-1:0] addr, input logic [DATA_W-1:0] expected,
                             input string name);
        logic [DATA_W-1:0] got;
        csr_read(addr, got);
        assert (got == expected) else
            stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
                                    $time, name, expected, got));
    endtask

    // upper halves carry junk that the DUT must ignore
    task automatic load_packet(input logic [DATA_W-1:0] base, input int words, input bit impulse);
        logic [DATA_W-1:0] word;
        for (int i = 0; i < words; i++) begin
            if (impulse) begin
                word = (i == 0) ? 32'h5a5a_0001 : 32'ha5a5_0000;
            end else begin
                word = $urandom;
            end
            sample_ref[i] = word[COEF_W-1:0];
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= base + DATA_W'(4 * i);
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_packet(input logic [DATA_W-1:0] base, input int words,
                              input logic [DATA_W-1:0] dest, input bit restart);
        logic [DATA_W-1:0] status;
        logic [DATA_W-1:0] end_addr;
        end_addr = base + DATA_W'(4 * words);
        for (int k = 0; k < NUM_TAPS; k++) begin
            csr_write(REG_COEF_SEL, DATA_W'(k));
            csr_write(REG_COEF_DATA, DATA_W'(coef_ref[k]));
        end
        csr_write(REG_PKT_BEGIN, base);
        csr_write(REG_PKT_END, end_addr);
        csr_write(REG_WRITE_ADDRESS, dest);
        check_reg(REG_PKT_BEGIN, base, "avs_s0_readdata (pkt_begin)");
        check_reg(REG_PKT_END, end_addr, "avs_s0_readdata (pkt_end)");
        check_reg(REG_WRITE_ADDRESS, dest, "avs_s0_readdata (write_address)");

        pkt_lo     <= base;
        pkt_hi     <= end_addr;
        exp_base   <= dest;
        exp_count  <= words;
        run_first  <= total_writes;
        run_active <= 1'b1;
        csr_write(REG_CONTROL, DATA_W'(1) << CTRL_START);
        if (restart) begin
            // a longer window here would make the reader fetch extra words
            csr_write(REG_PKT_END, end_addr + DATA_W'(32));
            check_reg(REG_PKT_END, end_addr, "avs_s0_readdata (pkt_end while busy)");
            // a start taken mid run would reload the write address and clear the taps
            while (total_writes - run_first < RESTART_AFTER) begin
                @(posedge clk);
            end
            csr_write(REG_CONTROL, DATA_W'(1) << CTRL_START);
        end

        status = '0;
        while (!status[CTRL_DONE]) begin
            csr_read(REG_CONTROL, status);
        end
        assert (!status[CTRL_BUSY]) else
            stop_on_error("busy is still set after the done bit rose");
        assert (total_writes - run_first == words) else
            stop_on_error($sformatf("** Error at %0t: write count expected %0d, got %0d",
                                    $time, words, total_writes - run_first));
        run_active <= 1'b0;
    endtask

    // every accepted m1 write is checked against the reference
    always @(posedge clk) begin
        int n;
        logic [DATA_W-1:0] expected;
        n = total_writes - run_first;
        if (arst_n && avs_m0_read) begin
            assert (run_active && avs_m0_address >= pkt_lo && avs_m0_address < pkt_hi) else
                stop_on_error($sformatf("m0 read at %h outside a run or its packet window",
                                        avs_m0_address));
            assert (avs_m0_burstcount == BURST_W'(1)) else
                stop_on_error($sformatf("** Error at %0t: avs_m0_burstcount expected 1, got %0d",
                                        $time, avs_m0_burstcount));
        end
        if (arst_n && avs_m1_write) begin
            assert (run_active && n < exp_count) else
                stop_on_error("m1 write with no result left to store");
            assert (avs_m1_burstcount == BURST_W'(1)) else
                stop_on_error($sformatf("** Error at %0t: avs_m1_burstcount expected 1, got %0d",
                                        $time, avs_m1_burstcount));
        end
        if (arst_n && avs_m1_write && !avs_m1_waitrequest) begin
            assert (avs_m1_address == exp_base + DATA_W'(4 * n)) else
                stop_on_error($sformatf("** Error at %0t: avs_m1_address expected %h, got %h",
                                        $time, exp_base + DATA_W'(4 * n), avs_m1_address));
            expected = fir_ref(n);
            assert (avs_m1_writedata == expected) else
                stop_on_error($sformatf("** Error at %0t: avs_m1_writedata expected %h, got %h",
                                        $time, expected, avs_m1_writedata));
            total_writes <= total_writes + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout after %0d cycles, the DUT never finished",
                                    cycle_count));
        end
    end

    initial begin
        void'($urandom(34));
        arst_n           <= 1'b0;
        avs_s0_address   <= '0;
        avs_s0_write     <= 1'b0;
        avs_s0_writedata <= '0;
        avs_s0_read      <= 1'b0;
        load_en          <= 1'b0;
        load_addr        <= '0;
        load_data        <= '0;
        run_active       <= 1'b0;
        exp_base         <= '0;
        exp_count        <= 0;
        run_first        <= 0;
        pkt_lo           <= '0;
        pkt_hi           <= '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        // idle after reset, the strobe monitor watches this stretch
        check_reg(REG_CONTROL, '0, "avs_s0_readdata (control)");
        repeat (20) @(posedge clk);

        // impulse, the first eight results are the coefficients
        coef_ref = '{16'sd3, -16'sd5, 16'sd7, 16'sd100, -16'sd1, 16'sd32767, 16'sh8000, 16'sd12};
        load_packet(32'h0000_0000, 12, 1'b1);
        run_packet(32'h0000_0000, 12, 32'h0000_0400, 1'b0);

        for (int k = 0; k < NUM_TAPS; k++) begin
            coef_ref[k] = COEF_W'($urandom);
        end
        load_packet(32'h0000_0100, 64, 1'b0);
        run_packet(32'h0000_0100, 64, 32'h0000_0600, 1'b0);

        // new coefficients and address, with a start and a window change while busy
        for (int k = 0; k < NUM_TAPS; k++) begin
            coef_ref[k] = COEF_W'($urandom);
        end
        load_packet(32'h0000_0200, 20, 1'b0);
        run_packet(32'h0000_0200, 20, 32'h0000_0a00, 1'b1);

        repeat (10) @(posedge clk);
        if (total_writes == TOTAL_WORDS) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_on_error($sformatf("** Error at %0t: total_writes expected %0d, got %0d",
                                    $time, TOTAL_WORDS, total_writes));
        end
    end

endmodule

//--- compile.f
hdl/bpfcap_pkg.sv
hdl/bpfcap_csr_if.sv
hdl/bpfcap_tap_if.sv
hdl/bpfcap_csr.sv
hdl/bpfcap_reader.sv
hdl/bpfcap_tap.sv
hdl/bpfcap_writer.sv
hdl/bpfcap_top.sv
testbench/tb_avalon_mem.sv
testbench/tb_bpfcap_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_bpfcap_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run fails with a nonzero exit status on any error
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
